// File: Makefile
# Verilator build and run of the GPIO testbench

VERILATOR ?= verilator
TOP       ?= gpio_top_tb
FILELIST  ?= gpio_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell cat $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, fail if the log reports errors"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "FAIL"; exit 1; fi
	@grep -q "Done: no errors" $(LOG) || { echo "FAIL: run ended early"; exit 1; }
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: gpio_top.f
hw/gpio_bus_pkg.sv
hw/gpio_pin_pkg.sv
hw/gpio_input_conditioner.sv
hw/gpio_edge_irq.sv
hw/gpio_regs.sv
hw/gpio_top.sv
tb/gpio_checker.sv
tb/gpio_top_properties.sv
tb/gpio_top_tb.sv

// File: hw/gpio_bus_pkg.sv
package gpio_bus_pkg;

    // ------------------------------
    // Bus widths
    // ------------------------------
    typedef logic [6:0]  bus_addr_t;
    typedef logic [31:0] bus_data_t;
    typedef logic [3:0]  bus_be_t;

    // One request per cycle with we and re exclusive
    typedef struct packed {
        logic      we;
        logic      re;
        bus_addr_t addr;
        bus_data_t wdata;
        bus_be_t   be;
    } bus_req_t;

    // ------------------------------
    // Register map
    // ------------------------------
    typedef enum bus_addr_t {
        REG_DATA_I  = 7'h00,
        REG_DATA_O  = 7'h04,
        REG_DIR     = 7'h08,
        REG_INT_EN  = 7'h0C,
        REG_INT_POL = 7'h14,
        REG_INT_ANY = 7'h18,
        REG_INT_STS = 7'h1C,
        REG_SET_O   = 7'h20,
        REG_CLR_O   = 7'h24,
        REG_TGL_O   = 7'h28,
        REG_DEB_TH  = 7'h2C,
        REG_DEB_EN  = 7'h30,
        REG_INV_IN  = 7'h34,
        REG_INV_OUT = 7'h38
    } reg_addr_e;

    localparam bus_data_t UNMAPPED_READ = 32'hDEAD_BEEF;

endpackage

// File: hw/gpio_edge_irq.sv
`timescale 1ns/1ns

module gpio_edge_irq #(
    parameter int NUM_PINS = 32
) (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic [NUM_PINS-1:0]    pins_clean_i,
    input  gpio_pin_pkg::irq_cfg_t irq_cfg_i,
    input  logic [NUM_PINS-1:0]    sts_clr_i,
    output logic [NUM_PINS-1:0]    irq_sts_o,
    output logic                   irq_o
);

    logic [NUM_PINS-1:0] pins_prev_q;
    logic [NUM_PINS-1:0] rise;
    logic [NUM_PINS-1:0] fall;
    logic [NUM_PINS-1:0] en;
    logic [NUM_PINS-1:0] pol;
    logic [NUM_PINS-1:0] any;
    logic [NUM_PINS-1:0] hit;

    assign en  = irq_cfg_i.en[NUM_PINS-1:0];
    assign pol = irq_cfg_i.pol[NUM_PINS-1:0];
    assign any = irq_cfg_i.any[NUM_PINS-1:0];

    // ------------------------------
    // Edge detect
    // ------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pins_prev_q <= '0;
        end else begin
            pins_prev_q <= pins_clean_i;
        end
    end

    assign rise = pins_clean_i & ~pins_prev_q;
    assign fall = ~pins_clean_i & pins_prev_q;

    // Any-edge overrides polarity
    assign hit = en & ((any & (rise | fall)) | (~any & pol & rise) | (~any & ~pol & fall));

    // ------------------------------
    // Sticky status and combined irq
    // ------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            irq_sts_o <= '0;
            irq_o     <= 1'b0;
        end else begin
            // New edge wins over a clear
            irq_sts_o <= (irq_sts_o & ~sts_clr_i) | hit;
            irq_o     <= |(irq_sts_o & en);
        end
    end

endmodule

// File: hw/gpio_input_conditioner.sv
`timescale 1ns/1ns

module gpio_input_conditioner #(
    parameter int NUM_PINS = 32
) (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic [NUM_PINS-1:0]      pins_i,
    input  logic [NUM_PINS-1:0]      inv_in_i,
    input  logic [NUM_PINS-1:0]      deb_en_i,
    input  gpio_pin_pkg::deb_count_t deb_th_i,
    output logic [NUM_PINS-1:0]      pins_clean_o
);
    import gpio_pin_pkg::*;

    logic [NUM_PINS-1:0] pins_inv;

    assign pins_inv = pins_i ^ inv_in_i;

    // ------------------------------
    // Per-pin debounce
    // ------------------------------
    for (genvar i = 0; i < NUM_PINS; i++) begin : gen_pin
        deb_count_t cnt_q;
        logic       differ;

        assign differ = pins_inv[i] ^ pins_clean_o[i];

        always_ff @(posedge clk or negedge reset_n) begin
            if (!reset_n) begin
                cnt_q           <= '0;
                pins_clean_o[i] <= 1'b0;
            end else if (!deb_en_i[i]) begin
                // Plain registered follow
                cnt_q           <= '0;
                pins_clean_o[i] <= pins_inv[i];
            end else if (!differ) begin
                cnt_q <= '0;
            end else if (cnt_q >= deb_th_i) begin
                // deb_th+1 differing cycles seen
                cnt_q           <= '0;
                pins_clean_o[i] <= pins_inv[i];
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

endmodule

// File: hw/gpio_pin_pkg.sv
package gpio_pin_pkg;

    // Upper bound on the pin count of one block
    localparam int MAX_PINS = 32;

    // Debounce threshold and per-pin counter
    typedef logic [15:0] deb_count_t;

    // ------------------------------
    // Interrupt configuration
    // ------------------------------
    // Low NUM_PINS bits of each field are live
    typedef struct packed {
        logic [MAX_PINS-1:0] en;
        logic [MAX_PINS-1:0] pol;
        logic [MAX_PINS-1:0] any;
    } irq_cfg_t;

endpackage

// File: hw/gpio_regs.sv
`timescale 1ns/1ns

module gpio_regs #(
    parameter int NUM_PINS = 32
) (
    input  logic                     clk,
    input  logic                     reset_n,
    input  gpio_bus_pkg::bus_req_t   bus_req_i,
    output gpio_bus_pkg::bus_data_t  rdata_o,
    output logic                     ack_o,
    output logic [NUM_PINS-1:0]      pins_o,
    output logic [NUM_PINS-1:0]      pins_oe_o,
    input  logic [NUM_PINS-1:0]      pins_clean_i,
    output logic [NUM_PINS-1:0]      inv_in_o,
    output logic [NUM_PINS-1:0]      deb_en_o,
    output gpio_pin_pkg::deb_count_t deb_th_o,
    output gpio_pin_pkg::irq_cfg_t   irq_cfg_o,
    output logic [NUM_PINS-1:0]      sts_clr_o,
    input  logic [NUM_PINS-1:0]      irq_sts_i
);
    import gpio_bus_pkg::*;
    import gpio_pin_pkg::*;

    typedef logic [NUM_PINS-1:0] pin_vec_t;

    if (NUM_PINS < 1 || NUM_PINS > MAX_PINS) begin : gen_num_pins_check
        $error("NUM_PINS is %0d, must be 1 to %0d", NUM_PINS, MAX_PINS);
    end

    pin_vec_t   data_o_q;
    pin_vec_t   dir_q;
    pin_vec_t   int_en_q;
    pin_vec_t   int_pol_q;
    pin_vec_t   int_any_q;
    pin_vec_t   deb_en_q;
    pin_vec_t   inv_in_q;
    pin_vec_t   inv_out_q;
    deb_count_t deb_th_q;

    bus_data_t  byte_mask;
    pin_vec_t   pin_mask;
    pin_vec_t   pin_wdata;
    bus_data_t  rdata_d;

    function automatic pin_vec_t merge(pin_vec_t old, pin_vec_t wdata, pin_vec_t mask);
        return (old & ~mask) | (wdata & mask);
    endfunction

    // One enable per 8 pins
    assign byte_mask = {{8{bus_req_i.be[3]}}, {8{bus_req_i.be[2]}},
                        {8{bus_req_i.be[1]}}, {8{bus_req_i.be[0]}}};
    assign pin_mask  = byte_mask[NUM_PINS-1:0];
    assign pin_wdata = bus_req_i.wdata[NUM_PINS-1:0];

    // ------------------------------
    // Register writes
    // ------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            data_o_q  <= '0;
            dir_q     <= '0;
            int_en_q  <= '0;
            int_pol_q <= '0;
            int_any_q <= '0;
            deb_en_q  <= '0;
            inv_in_q  <= '0;
            inv_out_q <= '0;
            deb_th_q  <= '0;
        end else if (bus_req_i.we) begin
            case (bus_req_i.addr)
                REG_DATA_O:  data_o_q  <= merge(data_o_q, pin_wdata, pin_mask);
                REG_SET_O:   data_o_q  <= data_o_q | (pin_wdata & pin_mask);
                REG_CLR_O:   data_o_q  <= data_o_q & ~(pin_wdata & pin_mask);
                REG_TGL_O:   data_o_q  <= data_o_q ^ (pin_wdata & pin_mask);
                REG_DIR:     dir_q     <= merge(dir_q, pin_wdata, pin_mask);
                REG_INT_EN:  int_en_q  <= merge(int_en_q, pin_wdata, pin_mask);
                REG_INT_POL: int_pol_q <= merge(int_pol_q, pin_wdata, pin_mask);
                REG_INT_ANY: int_any_q <= merge(int_any_q, pin_wdata, pin_mask);
                REG_DEB_EN:  deb_en_q  <= merge(deb_en_q, pin_wdata, pin_mask);
                REG_INV_IN:  inv_in_q  <= merge(inv_in_q, pin_wdata, pin_mask);
                REG_INV_OUT: inv_out_q <= merge(inv_out_q, pin_wdata, pin_mask);
                REG_DEB_TH:  deb_th_q  <= (deb_th_q & ~byte_mask[15:0]) |
                                          (bus_req_i.wdata[15:0] & byte_mask[15:0]);
                default: ;
            endcase
        end
    end

    // Write-one-to-clear pulse for the status bits
    assign sts_clr_o = (bus_req_i.we && bus_req_i.addr == REG_INT_STS) ?
                       (pin_wdata & pin_mask) : '0;

    // ------------------------------
    // Read mux and ack
    // ------------------------------
    always_comb begin
        rdata_d = '0;
        case (bus_req_i.addr)
            REG_DATA_I:  rdata_d[NUM_PINS-1:0] = pins_clean_i;
            REG_DATA_O:  rdata_d[NUM_PINS-1:0] = data_o_q;
            REG_DIR:     rdata_d[NUM_PINS-1:0] = dir_q;
            REG_INT_EN:  rdata_d[NUM_PINS-1:0] = int_en_q;
            REG_INT_POL: rdata_d[NUM_PINS-1:0] = int_pol_q;
            REG_INT_ANY: rdata_d[NUM_PINS-1:0] = int_any_q;
            REG_INT_STS: rdata_d[NUM_PINS-1:0] = irq_sts_i;
            REG_DEB_TH:  rdata_d[15:0]         = deb_th_q;
            REG_DEB_EN:  rdata_d[NUM_PINS-1:0] = deb_en_q;
            REG_INV_IN:  rdata_d[NUM_PINS-1:0] = inv_in_q;
            REG_INV_OUT: rdata_d[NUM_PINS-1:0] = inv_out_q;
            // SET, CLR and TGL are write only
            default:     rdata_d = UNMAPPED_READ;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ack_o   <= 1'b0;
            rdata_o <= '0;
        end else begin
            ack_o <= bus_req_i.we | bus_req_i.re;
            if (bus_req_i.re) begin
                rdata_o <= rdata_d;
            end
        end
    end

    // ------------------------------
    // Outputs to pins and units
    // ------------------------------
    assign pins_o    = data_o_q ^ inv_out_q;
    assign pins_oe_o = dir_q;
    assign inv_in_o  = inv_in_q;
    assign deb_en_o  = deb_en_q;
    assign deb_th_o  = deb_th_q;

    always_comb begin
        irq_cfg_o = '0;
        irq_cfg_o.en[NUM_PINS-1:0]  = int_en_q;
        irq_cfg_o.pol[NUM_PINS-1:0] = int_pol_q;
        irq_cfg_o.any[NUM_PINS-1:0] = int_any_q;
    end

endmodule

// File: hw/gpio_top.sv
`timescale 1ns/1ns

module gpio_top #(
    parameter int NUM_PINS = 32
) (
    input  logic                    clk,
    input  logic                    reset_n,
    input  gpio_bus_pkg::bus_req_t  bus_req_i,
    output gpio_bus_pkg::bus_data_t rdata_o,
    output logic                    ack_o,
    input  logic [NUM_PINS-1:0]     pins_i,
    output logic [NUM_PINS-1:0]     pins_o,
    output logic [NUM_PINS-1:0]     pins_oe_o,
    output logic                    irq_o
);
    import gpio_pin_pkg::*;

    logic [NUM_PINS-1:0] pins_clean;
    logic [NUM_PINS-1:0] inv_in;
    logic [NUM_PINS-1:0] deb_en;
    deb_count_t          deb_th;
    irq_cfg_t            irq_cfg;
    logic [NUM_PINS-1:0] sts_clr;
    logic [NUM_PINS-1:0] irq_sts;

    gpio_regs #(
        .NUM_PINS (NUM_PINS)
    ) u_regs (
        .clk          (clk),
        .reset_n      (reset_n),
        .bus_req_i    (bus_req_i),
        .rdata_o      (rdata_o),
        .ack_o        (ack_o),
        .pins_o       (pins_o),
        .pins_oe_o    (pins_oe_o),
        .pins_clean_i (pins_clean),
        .inv_in_o     (inv_in),
        .deb_en_o     (deb_en),
        .deb_th_o     (deb_th),
        .irq_cfg_o    (irq_cfg),
        .sts_clr_o    (sts_clr),
        .irq_sts_i    (irq_sts)
    );

    gpio_input_conditioner #(
        .NUM_PINS (NUM_PINS)
    ) u_cond (
        .clk          (clk),
        .reset_n      (reset_n),
        .pins_i       (pins_i),
        .inv_in_i     (inv_in),
        .deb_en_i     (deb_en),
        .deb_th_i     (deb_th),
        .pins_clean_o (pins_clean)
    );

    gpio_edge_irq #(
        .NUM_PINS (NUM_PINS)
    ) u_irq (
        .clk          (clk),
        .reset_n      (reset_n),
        .pins_clean_i (pins_clean),
        .irq_cfg_i    (irq_cfg),
        .sts_clr_i    (sts_clr),
        .irq_sts_o    (irq_sts),
        .irq_o        (irq_o)
    );

endmodule

// File: tb/gpio_checker.sv
`timescale 1ns/1ns

module gpio_checker (
    input logic                    clk,
    input logic                    reset_n,
    input gpio_bus_pkg::bus_req_t  bus_req_i,
    input logic [31:0]             pins_i,
    input gpio_bus_pkg::bus_data_t rdata_i,
    input logic                    ack_i,
    input logic [31:0]             pins_out_i,
    input logic [31:0]             pins_oe_i,
    input logic                    irq_i
);
    import gpio_bus_pkg::*;
    import gpio_pin_pkg::*;

    int          checks = 0;
    int          errors = 0;
    logic [31:0] data_o, dir, int_en, int_pol, int_any, deb_en, inv_in, inv_out;
    logic [31:0] clean, prev, sts;
    deb_count_t  th;
    deb_count_t  cnt [32];
    logic        exp_ack, exp_rd, exp_irq;
    bus_data_t   exp_rdata;

    function automatic bus_data_t model_read(bus_addr_t addr);
        case (addr)
            REG_DATA_I:  return clean;
            REG_DATA_O:  return data_o;
            REG_DIR:     return dir;
            REG_INT_EN:  return int_en;
            REG_INT_POL: return int_pol;
            REG_INT_ANY: return int_any;
            REG_INT_STS: return sts;
            REG_DEB_TH:  return {16'h0, th};
            REG_DEB_EN:  return deb_en;
            REG_INV_IN:  return inv_in;
            REG_INV_OUT: return inv_out;
            default:     return UNMAPPED_READ;
        endcase
    endfunction

    // ------------------------------
    // Cycle model from old state to new state
    // ------------------------------
    always @(posedge clk or negedge reset_n) begin
        bus_data_t   mask;
        bus_data_t   wv;
        logic [31:0] inv;
        logic [31:0] rise;
        logic [31:0] fall;
        logic [31:0] clr;
        if (!reset_n) begin
            {data_o, dir, int_en, int_pol, int_any, deb_en, inv_in, inv_out} = '0;
            {clean, prev, sts, th} = '0;
            {exp_ack, exp_rd, exp_irq} = '0;
            exp_rdata = '0;
            for (int i = 0; i < 32; i++) begin
                cnt[i] = '0;
            end
        end else begin
            mask = {{8{bus_req_i.be[3]}}, {8{bus_req_i.be[2]}},
                    {8{bus_req_i.be[1]}}, {8{bus_req_i.be[0]}}};
            wv = bus_req_i.wdata & mask;
            exp_ack = bus_req_i.we | bus_req_i.re;
            exp_rd  = bus_req_i.re;
            if (bus_req_i.re) begin
                exp_rdata = model_read(bus_req_i.addr);
            end
            clr = (bus_req_i.we && bus_req_i.addr == REG_INT_STS) ? wv : '0;
            exp_irq = |(sts & int_en);
            rise = clean & ~prev;
            fall = ~clean & prev;
            // Rising counts when any or pol, falling when any or not pol
            sts = (sts & ~clr) |
                  (int_en & ((rise & (int_any | int_pol)) | (fall & (int_any | ~int_pol))));
            prev = clean;
            inv = pins_i ^ inv_in;
            for (int i = 0; i < 32; i++) begin
                if (!deb_en[i]) begin
                    clean[i] = inv[i];
                    cnt[i]   = '0;
                end else if (inv[i] == clean[i]) begin
                    cnt[i] = '0;
                end else if (cnt[i] >= th) begin
                    clean[i] = inv[i];
                    cnt[i]   = '0;
                end else begin
                    cnt[i] = cnt[i] + 16'd1;
                end
            end
            if (bus_req_i.we) begin
                case (bus_req_i.addr)
                    REG_DATA_O:  data_o  = (data_o & ~mask) | wv;
                    REG_SET_O:   data_o  = data_o | wv;
                    REG_CLR_O:   data_o  = data_o & ~wv;
                    REG_TGL_O:   data_o  = data_o ^ wv;
                    REG_DIR:     dir     = (dir & ~mask) | wv;
                    REG_INT_EN:  int_en  = (int_en & ~mask) | wv;
                    REG_INT_POL: int_pol = (int_pol & ~mask) | wv;
                    REG_INT_ANY: int_any = (int_any & ~mask) | wv;
                    REG_DEB_EN:  deb_en  = (deb_en & ~mask) | wv;
                    REG_INV_IN:  inv_in  = (inv_in & ~mask) | wv;
                    REG_INV_OUT: inv_out = (inv_out & ~mask) | wv;
                    REG_DEB_TH:  th      = (th & ~mask[15:0]) | wv[15:0];
                    default: ;
                endcase
            end
        end
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("ERROR %s: got %h, expected %h", name, got, expected);
        end
    endtask

    // Outputs are all registered, so the falling edge sees them settled
    always @(negedge clk) begin
        if (reset_n) begin
            compare_value("ack_o", 32'(ack_i), 32'(exp_ack));
            if (exp_rd) begin
                compare_value("rdata_o", rdata_i, exp_rdata);
            end
            compare_value("pins_o", pins_out_i, data_o ^ inv_out);
            compare_value("pins_oe_o", pins_oe_i, dir);
            compare_value("irq_o", 32'(irq_i), 32'(exp_irq));
        end
    end

endmodule

// File: tb/gpio_top_properties.sv
`timescale 1ns/1ns

module gpio_top_properties (
    input logic                              clk,
    input logic                              reset_n,
    input gpio_bus_pkg::bus_req_t            bus_req_i,
    input logic                              ack_i,
    input logic                              irq_i,
    input logic [gpio_pin_pkg::MAX_PINS-1:0] irq_en_i
);

    logic req;
    int   fail_count = 0;

    assign req = bus_req_i.we | bus_req_i.re;

    ack_after_req: assert property (@(posedge clk) disable iff (!reset_n) req |=> ack_i)
    else begin
        $error("ack_o missing in the cycle after a request");
        fail_count++;
    end

    no_stray_ack: assert property (@(posedge clk) disable iff (!reset_n) !req |=> !ack_i)
    else begin
        $error("ack_o high without a request");
        fail_count++;
    end

    we_re_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
        !(bus_req_i.we && bus_req_i.re))
    else begin
        $error("we and re high together");
        fail_count++;
    end

    // irq_o lags the enables by one register
    irq_needs_enable: assert property (@(posedge clk) disable iff (!reset_n)
        (irq_en_i == '0) |=> !irq_i)
    else begin
        $error("irq_o high with no interrupt enabled");
        fail_count++;
    end

endmodule

bind gpio_top gpio_top_properties u_props (
    .clk       (clk),
    .reset_n   (reset_n),
    .bus_req_i (bus_req_i),
    .ack_i     (ack_o),
    .irq_i     (irq_o),
    .irq_en_i  (irq_cfg.en)
);

// File: tb/gpio_top_tb.sv
`timescale 1ns/1ns

module gpio_top_tb;
    import gpio_bus_pkg::*;
    import gpio_pin_pkg::*;

    localparam int NUM_PINS     = 32;
    localparam int RESET_CYCLES = 8;
    localparam int N_BUS_OPS    = 600;
    localparam int N_PIN_STEPS  = 80;
    localparam int MAX_TH       = 8;
    // Pin step worst case is a glitch plus settle plus a few accesses
    localparam int PLAN_CYCLES  = RESET_CYCLES + N_BUS_OPS + N_PIN_STEPS * (2 * MAX_TH + 16);
    localparam int CYCLE_LIMIT  = 2 * PLAN_CYCLES;

    localparam bus_addr_t REG_LIST [14] = '{
        REG_DATA_I, REG_DATA_O, REG_DIR, REG_INT_EN, REG_INT_POL, REG_INT_ANY, REG_INT_STS,
        REG_SET_O, REG_CLR_O, REG_TGL_O, REG_DEB_TH, REG_DEB_EN, REG_INV_IN, REG_INV_OUT
    };
    localparam bus_addr_t CFG_LIST [5] = '{
        REG_INV_IN, REG_DEB_EN, REG_INT_EN, REG_INT_POL, REG_INT_ANY
    };

    logic                clk;
    logic                reset_n;
    bus_req_t            bus_req;
    bus_data_t           rdata;
    logic                ack;
    logic [NUM_PINS-1:0] pins_in;
    logic [NUM_PINS-1:0] pins_out;
    logic [NUM_PINS-1:0] pins_oe;
    logic                irq;
    logic [31:0]         lcg_state;
    int                  cycles;
    deb_count_t          cur_th;
    int                  assert_fails;

    always begin
        clk = 1'b0;
        #10;
        clk = 1'b1;
        #10;
    end

    gpio_top #(
        .NUM_PINS (NUM_PINS)
    ) i_dut (
        .clk       (clk),
        .reset_n   (reset_n),
        .bus_req_i (bus_req),
        .rdata_o   (rdata),
        .ack_o     (ack),
        .pins_i    (pins_in),
        .pins_o    (pins_out),
        .pins_oe_o (pins_oe),
        .irq_o     (irq)
    );

    gpio_checker u_checker (
        .clk        (clk),
        .reset_n    (reset_n),
        .bus_req_i  (bus_req),
        .pins_i     (pins_in),
        .rdata_i    (rdata),
        .ack_i      (ack),
        .pins_out_i (pins_out),
        .pins_oe_i  (pins_oe),
        .irq_i      (irq)
    );

    always @(posedge clk) begin
        if (!reset_n) begin
            cycles <= 0;
        end else begin
            cycles <= cycles + 1;
            if (cycles >= CYCLE_LIMIT) begin
                $display("Timeout: run still going after %0d cycles", cycles);
                $display("Done: errors found");
                $finish;
            end
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // ------------------------------
    // Bus and pin stimulus
    // ------------------------------
    task automatic issue_request(input logic we, input bus_addr_t addr,
                                 input bus_data_t wdata, input bus_be_t be);
        @(negedge clk);
        bus_req.we    = we;
        bus_req.re    = ~we;
        bus_req.addr  = addr;
        bus_req.wdata = wdata;
        bus_req.be    = be;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            bus_req = '0;
        end
    endtask

    task automatic random_access();
        logic [31:0] r;
        bus_data_t   d;
        bus_addr_t   addr;
        r = lcg_next();
        d = lcg_next();
        if (r[2:0] == 3'd0) begin
            // Hole in the map, or past the last register
            addr = r[8] ? 7'h10 : bus_addr_t'(32'd60 + r % 32'd68);
        end else begin
            addr = REG_LIST[int'(r[31:16] % 16'd14)];
        end
        if (addr == REG_DEB_TH) begin
            // Small thresholds keep the pin phase short
            d = d & 32'hFFFF_000F;
        end
        issue_request(r[3], addr, d, r[7:4]);
    endtask

    task automatic pin_step();
        logic [31:0]         r;
        logic [NUM_PINS-1:0] old_pins;
        int                  glitch;
        r = lcg_next();
        old_pins = pins_in;
        if (r[1:0] == 2'd0) begin
            issue_request(1'b1, CFG_LIST[int'(r[10:8]) % 5], lcg_next(), r[7:4]);
        end
        idle_cycles(1);
        pins_in = old_pins ^ (lcg_next() & lcg_next());
        if (r[2]) begin
            // Shorter than deb_th+1 cycles
            glitch = 1 + int'(r[15:8]) % int'(cur_th);
            idle_cycles(glitch);
            pins_in = old_pins;
        end
        // Status clears land at random points around the edges
        repeat (int'(cur_th) + 3) begin
            r = lcg_next();
            case (r[1:0])
                2'd0:    issue_request(1'b1, REG_INT_STS, lcg_next(), r[7:4]);
                2'd1:    issue_request(1'b0, REG_INT_STS, '0, '0);
                default: idle_cycles(1);
            endcase
        end
        issue_request(1'b0, REG_DATA_I, '0, '0);
        issue_request(1'b0, REG_INT_STS, '0, '0);
        issue_request(1'b1, REG_INT_STS, 32'hFFFF_FFFF, 4'hF);
    endtask

    initial begin
        lcg_state = 32'h01d1_38eb;
        reset_n   = 1'b0;
        bus_req   = '0;
        pins_in   = '0;
        cur_th    = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset_n = 1'b1;

        repeat (N_BUS_OPS) random_access();
        idle_cycles(2);

        cur_th = deb_count_t'(32'd1 + lcg_next() % 32'(MAX_TH));
        issue_request(1'b1, REG_DEB_TH, bus_data_t'(cur_th), 4'hF);
        repeat (N_PIN_STEPS) pin_step();
        idle_cycles(4);

        assert_fails = i_dut.u_props.fail_count;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 u_checker.checks, u_checker.errors, assert_fails);
        if (u_checker.errors == 0 && assert_fails == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
